// ==== src/arcade_pkg.sv ====
package arcade_pkg;

	typedef logic [6:0]  game_id_t;     // core_mod
	typedef logic [31:0] status_t;      // osd option word
	typedef logic [24:0] ioctl_addr_t;  // download byte address

	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic fire_a;
		logic fire_b;
	} player_t;

	typedef struct packed {
		logic coin;
		logic start1;
		logic start2;
	} panel_t;

	// active-low input and dip banks as seen by the core
	typedef struct packed {
		logic [7:0] inp0;
		logic [7:0] inp1;
		logic [7:0] inp2;
		logic [7:0] dsw0;
		logic [7:0] dsw1;
	} inp_bank_t;

	typedef struct packed {
		logic [22:0] addr;  // 16-bit word address
		logic [1:0]  ds;
		logic [15:0] data;
		logic        we;
	} sdram_wr_t;

	localparam game_id_t game_flicky      = 7'd0;
	localparam game_id_t game_pitfall2    = 7'd1;
	localparam game_id_t game_starjacker  = 7'd2;
	localparam game_id_t game_regulus     = 7'd3;
	localparam game_id_t game_upndown     = 7'd4;
	localparam game_id_t game_myhero      = 7'd5;
	localparam game_id_t game_ninja       = 7'd6;
	localparam game_id_t game_mrviking    = 7'd7;

	// status word fields
	localparam int st_reset      = 0;
	localparam int st_rotate     = 2;
	localparam int st_service    = 6;
	localparam int st_crypt      = 7;
	localparam int st_lives      = 8;   // 2 bits
	localparam int st_extend     = 10;  // 2 bits
	localparam int st_difficulty = 12;

	// ps/2 set 2 make codes
	localparam logic [7:0] key_coin   = 8'h2e;  // 5
	localparam logic [7:0] key_start1 = 8'h16;  // 1
	localparam logic [7:0] key_start2 = 8'h1e;  // 2

endpackage

// ==== src/arcade_controls.sv ====
`timescale 1ns/1ps

module arcade_controls (
	input  logic                 clk_sys,
	input  logic                 rst_n,
	input  logic [7:0]           joystick_0,
	input  logic [7:0]           joystick_1,
	input  logic                 key_strobe,
	input  logic                 key_pressed,
	input  logic [7:0]           key_code,
	input  logic                 rotate,
	output arcade_pkg::player_t  player1,
	output arcade_pkg::player_t  player2,
	output arcade_pkg::panel_t   panel
);

	logic coin_held;
	logic start1_held;
	logic start2_held;

	// joystick bits: 0 right, 1 left, 2 down, 3 up, 4 fire a, 5 fire b
	function automatic arcade_pkg::player_t map_joy(input logic [7:0] joy, input logic rot);
		arcade_pkg::player_t p;
		p.fire_a = joy[4];
		p.fire_b = joy[5];
		if (rot)
		begin
			// clockwise, cabinet turned for a vertical screen
			p.up    = joy[0];
			p.right = joy[2];
			p.down  = joy[1];
			p.left  = joy[3];
		end
		else
		begin
			p.up    = joy[3];
			p.down  = joy[2];
			p.left  = joy[1];
			p.right = joy[0];
		end
		return p;
	endfunction

	always_ff @(posedge clk_sys or negedge rst_n)
	begin
		if (!rst_n)
		begin
			coin_held   <= 1'b0;
			start1_held <= 1'b0;
			start2_held <= 1'b0;
		end
		else if (key_strobe)
		begin
			case (key_code)
				arcade_pkg::key_coin:   coin_held   <= key_pressed;
				arcade_pkg::key_start1: start1_held <= key_pressed;
				arcade_pkg::key_start2: start2_held <= key_pressed;
				default: ;  // other keys ignored
			endcase
		end
	end

	assign player1 = map_joy(joystick_0, rotate);
	assign player2 = map_joy(joystick_1, rotate);

	assign panel.coin   = coin_held;
	assign panel.start1 = start1_held;
	assign panel.start2 = start2_held;

endmodule

// ==== src/game_input_map.sv ====
`timescale 1ns/1ps

module game_input_map (
	input  logic                   clk_sys,
	input  logic                   rst_n,
	input  arcade_pkg::game_id_t   core_mod,
	input  arcade_pkg::status_t    status,
	input  arcade_pkg::player_t    player1,
	input  arcade_pkg::player_t    player2,
	input  arcade_pkg::panel_t     panel,
	output arcade_pkg::inp_bank_t  banks,
	output logic                   crypt
);

	arcade_pkg::inp_bank_t bank_d;
	logic known;
	logic has_ud;   // up/down wired
	logic has_fb;   // second button wired
	logic svc;
	logic [7:0] dip1;

	// left, right, up, down, -, fire a, fire b, -  then inverted
	function automatic logic [7:0] stick_byte(input arcade_pkg::player_t p, input logic ud,
		input logic fb);
		return ~{p.left, p.right, p.up & ud, p.down & ud, 1'b0, p.fire_a, p.fire_b & fb, 1'b0};
	endfunction

	assign dip1 = {1'b0,
		~status[arcade_pkg::st_difficulty],
		~status[arcade_pkg::st_extend +: 2],
		~status[arcade_pkg::st_lives +: 2],
		2'b00};

	always_comb
	begin
		known  = 1'b1;
		has_ud = 1'b1;
		has_fb = 1'b0;
		svc    = ~status[arcade_pkg::st_service];
		case (core_mod)
			arcade_pkg::game_flicky:
			begin
				has_ud = 1'b0;
				svc    = 1'b0;
			end
			arcade_pkg::game_pitfall2:
			begin
				has_ud = 1'b0;
				has_fb = 1'b1;
				svc    = 1'b0;
			end
			arcade_pkg::game_starjacker,
			arcade_pkg::game_regulus:   has_fb = 1'b1;
			arcade_pkg::game_upndown,
			arcade_pkg::game_myhero,
			arcade_pkg::game_ninja,
			arcade_pkg::game_mrviking:  has_fb = 1'b0;
			default:                    known  = 1'b0;
		endcase

		if (known)
		begin
			bank_d.inp0 = stick_byte(player1, has_ud, has_fb);
			bank_d.inp1 = stick_byte(player2, has_ud, has_fb);
			bank_d.inp2 = ~{2'b00, panel.start2, panel.start1, svc, 2'b00, panel.coin};
			bank_d.dsw0 = 8'hff;
			bank_d.dsw1 = dip1;
		end
		else
			bank_d = '1;  // nothing pressed, all switches off
	end

	always_ff @(posedge clk_sys or negedge rst_n)
	begin
		if (!rst_n)
		begin
			banks <= '1;
			crypt <= 1'b0;
		end
		else
		begin
			banks <= bank_d;
			crypt <= ~status[arcade_pkg::st_crypt];  // option reads "crypt off"
		end
	end

endmodule

// ==== src/rom_download_ctrl.sv ====
`timescale 1ns/1ps

module rom_download_ctrl #(
	parameter arcade_pkg::ioctl_addr_t tile_base = 25'h22000
) (
	input  logic                     clk_sys,
	input  logic                     rst_n,
	input  logic                     ioctl_download,
	input  logic                     ioctl_wr,
	input  arcade_pkg::ioctl_addr_t  ioctl_addr,
	input  logic [7:0]               ioctl_dout,
	input  logic                     status_reset,
	input  logic                     button_reset,
	output logic                     port1_req,
	output arcade_pkg::sdram_wr_t    port1,
	output logic                     port2_req,
	output arcade_pkg::sdram_wr_t    port2,
	output logic                     core_reset
);

	logic wr_last;
	logic download_last;
	logic rom_loaded;
	logic wr_rise;
	arcade_pkg::ioctl_addr_t tile_offset;

	assign wr_rise = ioctl_download & ioctl_wr & ~wr_last;
	assign tile_offset = ioctl_addr - tile_base;

	always_ff @(posedge clk_sys or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_last   <= 1'b0;
			port1_req <= 1'b0;
			port2_req <= 1'b0;
			port1     <= '0;
			port2     <= '0;
		end
		else
		begin
			wr_last <= ioctl_wr;
			if (wr_rise)
			begin
				port1_req <= ~port1_req;
				port2_req <= ~port2_req;

				// program roms, byte lane from address bit 0
				port1.addr <= ioctl_addr[23:1];
				port1.ds   <= {ioctl_addr[0], ~ioctl_addr[0]};
				port1.data <= {ioctl_dout, ioctl_dout};
				port1.we   <= 1'b1;

				// tile roms interleaved into 32-bit words
				port2.addr <= {6'd0, tile_offset[17:16], tile_offset[13:0], tile_offset[15]};
				port2.ds   <= {tile_offset[14], ~tile_offset[14]};
				port2.data <= {ioctl_dout, ioctl_dout};
				port2.we   <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk_sys or negedge rst_n)
	begin
		if (!rst_n)
		begin
			download_last <= 1'b0;
			rom_loaded    <= 1'b0;
			core_reset    <= 1'b1;
		end
		else
		begin
			download_last <= ioctl_download;
			if (download_last & ~ioctl_download)
				rom_loaded <= 1'b1;  // sticky
			core_reset <= status_reset | button_reset | ~rom_loaded;
		end
	end

endmodule

// ==== src/arcade_shell.sv ====
`timescale 1ns/1ps

module arcade_shell #(
	parameter arcade_pkg::ioctl_addr_t tile_base = 25'h22000
) (
	input  logic                     clk_sys,
	input  logic                     rst_n,
	input  logic [7:0]               joystick_0,
	input  logic [7:0]               joystick_1,
	input  logic                     key_strobe,
	input  logic                     key_pressed,
	input  logic [7:0]               key_code,
	input  arcade_pkg::status_t      status,
	input  arcade_pkg::game_id_t     core_mod,
	input  logic                     button_reset,
	input  logic                     ioctl_download,
	input  logic                     ioctl_wr,
	input  arcade_pkg::ioctl_addr_t  ioctl_addr,
	input  logic [7:0]               ioctl_dout,
	output arcade_pkg::inp_bank_t    banks,
	output logic                     crypt,
	output logic                     port1_req,
	output arcade_pkg::sdram_wr_t    port1,
	output logic                     port2_req,
	output arcade_pkg::sdram_wr_t    port2,
	output logic                     core_reset
);

	arcade_pkg::player_t player1;
	arcade_pkg::player_t player2;
	arcade_pkg::panel_t  panel;

	arcade_controls i_arcade_controls (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.joystick_0  (joystick_0),
		.joystick_1  (joystick_1),
		.key_strobe  (key_strobe),
		.key_pressed (key_pressed),
		.key_code    (key_code),
		.rotate      (status[arcade_pkg::st_rotate]),
		.player1     (player1),
		.player2     (player2),
		.panel       (panel)
	);

	game_input_map i_game_input_map (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.core_mod (core_mod),
		.status   (status),
		.player1  (player1),
		.player2  (player2),
		.panel    (panel),
		.banks    (banks),
		.crypt    (crypt)
	);

	rom_download_ctrl #(
		.tile_base (tile_base)
	) i_rom_download_ctrl (
		.clk_sys        (clk_sys),
		.rst_n          (rst_n),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.status_reset   (status[arcade_pkg::st_reset]),  // osd reset entry
		.button_reset   (button_reset),
		.port1_req      (port1_req),
		.port1          (port1),
		.port2_req      (port2_req),
		.port2          (port2),
		.core_reset     (core_reset)
	);

endmodule

// ==== tb/clock_gen.sv ====
`timescale 1ns/1ps

module clock_gen (
	output logic clk_sys,
	output logic rst_n
);

	initial
	begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;  // 10 ns period
	end

	initial
	begin
		rst_n = 1'b0;
		repeat (8) @(posedge clk_sys);
		@(negedge clk_sys);  // release mid-cycle
		rst_n = 1'b1;
	end

endmodule

// ==== tb/tb_arcade_shell.sv ====
`timescale 1ns/1ps

module tb_arcade_shell;

	localparam arcade_pkg::ioctl_addr_t tile_base = 25'h22000;
	localparam int wait_limit = 20;

	logic clk_sys;
	logic rst_n;
	logic [7:0] joystick_0;
	logic [7:0] joystick_1;
	logic key_strobe;
	logic key_pressed;
	logic [7:0] key_code;
	arcade_pkg::status_t status;
	arcade_pkg::game_id_t core_mod;
	logic button_reset;
	logic ioctl_download;
	logic ioctl_wr;
	arcade_pkg::ioctl_addr_t ioctl_addr;
	logic [7:0] ioctl_dout;
	arcade_pkg::inp_bank_t banks;
	logic crypt;
	logic port1_req;
	arcade_pkg::sdram_wr_t port1;
	logic port2_req;
	arcade_pkg::sdram_wr_t port2;
	logic core_reset;

	logic [31:0] lfsr;
	logic [2:0] keys_held;  // coin, start1, start2

	clock_gen i_clock_gen (.clk_sys(clk_sys), .rst_n(rst_n));

	arcade_shell #(.tile_base(tile_base)) i_arcade_shell (.*);

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("*** TEST FAILED ***");
		$fatal(1, "stopping at first error");
	endtask

	task automatic check_equal(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		assert (got === exp)
		else
			abort_run($sformatf("** Error at %0t ns: %s is %0h, expected %0h",
				$time, name, got, exp));
	endtask

	task automatic step();
		@(posedge clk_sys);
		#1;
	endtask

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic random_byte(output logic [7:0] b);
		for (int i = 0; i < 8; i++)
		begin
			lfsr = lfsr_next(lfsr);
			b[i] = lfsr[0];
		end
	endtask

	// joystick: 0 right, 1 left, 2 down, 3 up, 4 fire a, 5 fire b
	function automatic logic [7:0] exp_stick(input logic [6:0] g, input logic [7:0] j,
		input logic rot);
		logic [7:0] b;
		b = 8'h00;
		if (g > 7)
			return 8'hff;
		b[7] = rot ? j[3] : j[1];  // left
		b[6] = rot ? j[2] : j[0];  // right
		if (g >= 2)
		begin
			b[5] = rot ? j[0] : j[3];
			b[4] = rot ? j[1] : j[2];
		end
		b[2] = j[4];
		if (g == 1 || g == 2 || g == 3)
			b[1] = j[5];
		return ~b;
	endfunction

	function automatic logic [7:0] exp_inp2(input logic [6:0] g, input logic [31:0] st,
		input logic [2:0] keys);
		logic [7:0] b;
		b = 8'h00;
		if (g > 7)
			return 8'hff;
		b[0] = keys[2];
		b[4] = keys[1];
		b[5] = keys[0];
		if (g >= 2)
			b[3] = ~st[6];  // service
		return ~b;
	endfunction

	function automatic logic [7:0] exp_dsw1(input logic [6:0] g, input logic [31:0] st);
		if (g > 7)
			return 8'hff;
		return {1'b0, ~st[12], ~st[11:10], ~st[9:8], 2'b00};
	endfunction

	task automatic check_banks(input logic [6:0] g, input logic [31:0] st);
		check_equal("banks.inp2", banks.inp2, exp_inp2(g, st, keys_held));
		check_equal("banks.dsw0", banks.dsw0, 8'hff);
		check_equal("banks.dsw1", banks.dsw1, exp_dsw1(g, st));
		check_equal("crypt", crypt, !st[7]);
	endtask

	task automatic map_game(input logic [6:0] g, input logic [31:0] st);
		logic [7:0] j0;
		logic [7:0] j1;
		core_mod = g;
		status = st;
		for (int n = 0; n < 6; n++)
		begin
			random_byte(j0);
			random_byte(j1);
			joystick_0 = j0;
			joystick_1 = j1;
			step();
			check_equal("banks.inp0", banks.inp0, exp_stick(g, j0, st[2]));
			check_equal("banks.inp1", banks.inp1, exp_stick(g, j1, st[2]));
			check_banks(g, st);
		end
	endtask

	task automatic press_keys(input logic [6:0] g, input logic [31:0] st);
		logic [7:0] codes [4];
		codes = '{arcade_pkg::key_coin, arcade_pkg::key_start1, arcade_pkg::key_start2, 8'h1c};
		core_mod = g;
		status = st;
		for (int k = 0; k < 4; k++)
		begin
			for (int p = 1; p >= 0; p--)
			begin
				key_code = codes[k];
				key_pressed = p[0];
				key_strobe = 1'b1;
				step();
				key_strobe = 1'b0;
				if (k < 3)
					keys_held[2 - k] = p[0];  // code 1c is not a panel key
				step();
				check_banks(g, st);
			end
		end
	endtask

	task automatic download_write(input arcade_pkg::ioctl_addr_t addr, input logic [7:0] dout,
		input logic [22:0] exp1, input logic [22:0] exp2);
		logic req1;
		logic req2;
		int n;
		arcade_pkg::ioctl_addr_t off;
		req1 = port1_req;
		req2 = port2_req;
		off = addr - tile_base;
		ioctl_download = 1'b1;
		ioctl_addr = addr;
		ioctl_dout = dout;
		ioctl_wr = 1'b1;
		n = 0;
		do
		begin
			step();
			n++;
			check_equal("core_reset", core_reset, 1'b1);
			assert (n < wait_limit)
			else
				abort_run("port 1 request never toggled on a download write");
		end
		while (port1_req === req1);
		assert (n == 1)
		else
			abort_run("port requests toggled later than the first edge of the write");
		check_equal("port2_req", port2_req, !req2);
		check_equal("port1.addr", port1.addr, exp1);
		check_equal("port1.ds", port1.ds, {addr[0], ~addr[0]});
		check_equal("port1.data", port1.data, {dout, dout});
		check_equal("port1.we", port1.we, 1'b1);
		check_equal("port2.addr", port2.addr, exp2);
		check_equal("port2.ds", port2.ds, {off[14], ~off[14]});
		check_equal("port2.data", port2.data, {dout, dout});
		check_equal("port2.we", port2.we, 1'b1);
		for (int i = 0; i < 4; i++)
		begin
			if (i == 2)
				ioctl_wr = 1'b0;
			step();
			check_equal("port1_req", port1_req, !req1);  // one toggle per pulse
			check_equal("port2_req", port2_req, !req2);
		end
	endtask

	task automatic stray_write(input arcade_pkg::ioctl_addr_t addr, input logic [7:0] dout);
		logic req1;
		logic req2;
		req1 = port1_req;
		req2 = port2_req;
		ioctl_addr = addr;
		ioctl_dout = dout;
		ioctl_wr = 1'b1;
		for (int i = 0; i < 4; i++)
		begin
			if (i == 2)
				ioctl_wr = 1'b0;
			step();
			check_equal("port1_req", port1_req, req1);
			check_equal("port2_req", port2_req, req2);
		end
	endtask

	task automatic finish_download();
		ioctl_download = 1'b0;
		step();
		check_equal("core_reset", core_reset, 1'b1);
		step();
		check_equal("core_reset", core_reset, 1'b0);
		status[arcade_pkg::st_reset] = 1'b1;
		step();
		check_equal("core_reset", core_reset, 1'b1);
		status[arcade_pkg::st_reset] = 1'b0;
		step();
		check_equal("core_reset", core_reset, 1'b0);
		button_reset = 1'b1;
		step();
		check_equal("core_reset", core_reset, 1'b1);
		button_reset = 1'b0;
		step();
		check_equal("core_reset", core_reset, 1'b0);
	endtask

	initial
	begin
		int fd;
		int code;
		int n;
		int records;
		logic [8*128-1:0] line;
		logic [31:0] op, game, stat, addr, dout, p1, p2;
		joystick_0 = '0;
		joystick_1 = '0;
		key_strobe = 1'b0;
		key_pressed = 1'b0;
		key_code = '0;
		status = '0;
		core_mod = '0;
		button_reset = 1'b0;
		ioctl_download = 1'b0;
		ioctl_wr = 1'b0;
		ioctl_addr = '0;
		ioctl_dout = '0;
		lfsr = 32'h0d08d78a;
		keys_held = '0;
		records = 0;

		n = 0;
		do
		begin
			step();
			n++;
			if (rst_n === 1'b0)
			begin
				check_equal("banks", banks, arcade_pkg::inp_bank_t'('1));
				check_equal("crypt", crypt, 1'b0);
				check_equal("port1_req", port1_req, 1'b0);
				check_equal("port2_req", port2_req, 1'b0);
				check_equal("port1", port1, '0);
				check_equal("port2", port2, '0);
				check_equal("core_reset", core_reset, 1'b1);
			end
			assert (n < wait_limit)
			else
				abort_run("reset was never released");
		end
		while (rst_n !== 1'b1);

		fd = $fopen("tb/arcade_tests.txt", "r");
		assert (fd != 0)
		else
			abort_run("cannot open tb/arcade_tests.txt");
		code = $fgets(line, fd);  // two column header lines
		code = $fgets(line, fd);
		while (!$feof(fd))
		begin
			code = $fscanf(fd, "%h %h %h %h %h %h %h\n", op, game, stat, addr, dout, p1, p2);
			if (code == 7)
			begin
				records++;
				case (op)
					1: map_game(game[6:0], stat);
					2: press_keys(game[6:0], stat);
					3: download_write(addr[24:0], dout[7:0], p1[22:0], p2[22:0]);
					4: stray_write(addr[24:0], dout[7:0]);
					5: finish_download();
					default: abort_run($sformatf("unknown operation %0h in the tests file", op));
				endcase
			end
			else if (code >= 0)
				abort_run($sformatf("malformed record after record %0d", records));
		end
		$fclose(fd);
		assert (records > 0)
		else
			abort_run("the tests file holds no records");

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

// ==== tb/arcade_tests.txt ====
# op game status addr dout p1_addr p2_addr, all hex
# op 1 game map, 2 keys, 3 download write, 4 write outside download, 5 end of download
4 00 00000000 0001234 77 000000 00000
3 00 00000000 0000001 a5 000000 0c003
3 00 00000000 0012346 5a 0091a3 1868c
3 00 00000000 0022000 11 011000 00000
3 00 00000000 002a5a5 c3 0152d2 00b4b
3 00 00000000 0036789 96 01b3c4 08f12
3 00 00000000 003c000 0f 01e000 0c001
5 00 00000000 0000000 00 000000 00000
4 00 00000000 0022000 77 000000 00000
1 00 000000c0 0000000 00 000000 00000
1 01 00001500 0000000 00 000000 00000
1 02 00000000 0000000 00 000000 00000
1 03 00000a40 0000000 00 000000 00000
1 04 00000004 0000000 00 000000 00000
1 05 00000344 0000000 00 000000 00000
1 06 00001080 0000000 00 000000 00000
1 07 00000f00 0000000 00 000000 00000
1 03 00000004 0000000 00 000000 00000
1 01 00000004 0000000 00 000000 00000
1 08 00000000 0000000 00 000000 00000
1 7f 000000c4 0000000 00 000000 00000
2 00 00000040 0000000 00 000000 00000
2 05 00000000 0000000 00 000000 00000
2 09 00000000 0000000 00 000000 00000

// ==== verilog.f ====
src/arcade_pkg.sv
src/arcade_controls.sv
src/game_input_map.sv
src/rom_download_ctrl.sv
src/arcade_shell.sv
tb/clock_gen.sv
tb/tb_arcade_shell.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

log=sim.log
rm -f "$log"

verilator --binary --timing -Wno-fatal -f verilog.f --top-module tb_arcade_shell \
	-Mdir obj_dir -o sim_arcade_shell
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/sim_arcade_shell > "$log" 2>&1
sim_status=$?
cat "$log"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
fi

if grep -q -F "*** TEST PASSED ***" "$log"; then
	exit 0
fi
echo "simulation failed, see $log"
exit 1
